/* Makefile */
TOP = execTopTb

all: sim

lint:
	verilator --lint-only --timing --assert -f rvExecUnit.f --top-module $(TOP)

build:
	verilator --binary --timing --assert -f rvExecUnit.f --top-module $(TOP) --Mdir obj_dir

sim: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "Run failed"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then echo "Run gave no result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint build sim clean

/* rvExecUnit.f */
source/isaPkg.sv
source/aluPkg.sv
source/instrDecoder.sv
source/Alu.sv
source/regFile.sv
source/execTop.sv
verif/execTop_checker.sv
verif/execTopTb.sv

/* source/Alu.sv */
`timescale 1ns/1ps

module Alu import aluPkg::*; (
    input  aluOp    op,
    input  dataWord aluInX,
    input  dataWord aluInY,
    output dataWord aluOutS,
    output logic    zr
);

    logic [4:0] shamt;

    assign shamt = aluInY[4:0];  // ISA uses low five bits only

    assign zr = ~(|aluOutS);

    always_comb begin
        case (op)
            opAnd:
                aluOutS = aluInX & aluInY;
            opOr:
                aluOutS = aluInX | aluInY;
            opAdd:
                aluOutS = aluInX + aluInY;
            opSub:
                aluOutS = aluInX - aluInY;
            opSlt:  // Signed compare
                aluOutS = ($signed(aluInX) < $signed(aluInY)) ? 32'h1 : 32'h0;
            opSltu:
                aluOutS = (aluInX < aluInY) ? 32'h1 : 32'h0;
            opXor:
                aluOutS = aluInX ^ aluInY;
            opSll:
                aluOutS = aluInX << shamt;
            opSrl:
                aluOutS = aluInX >> shamt;
            opSra:  // Sign bit fills from the left
                aluOutS = dataWord'($signed(aluInX) >>> shamt);
            default:
                aluOutS = aluInX;  // Unknown code passes X through
        endcase
    end

endmodule

/* source/aluPkg.sv */
package aluPkg;

    typedef logic [31:0] dataWord;

    // Four-bit ALU operation codes
    typedef enum logic [3:0] {
        opAnd  = 4'b0000,
        opOr   = 4'b0001,
        opAdd  = 4'b0010,
        opSra  = 4'b0011,
        opSub  = 4'b0110,
        opSlt  = 4'b0111,
        opSll  = 4'b1000,
        opSrl  = 4'b1001,
        opXor  = 4'b1010,
        opSltu = 4'b1111
    } aluOp;

    // Wishbone word addresses
    localparam int wbAdrWidth = 6;

    localparam logic [wbAdrWidth-1:0] adrInstr   = 6'd0;   // Write executes
    localparam logic [wbAdrWidth-1:0] adrStatus  = 6'd1;   // Write clears illegal flag
    localparam logic [wbAdrWidth-1:0] adrRegBase = 6'd32;  // x0 to x31 at 32 to 63

    // Status word bit positions
    localparam int statIllegal = 0;
    localparam int statZero    = 1;

endpackage

/* source/execTop.sv */
`timescale 1ns/1ps

module execTop import isaPkg::*, aluPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [wbAdrWidth-1:0] adr,
    input  dataWord               datWr,
    output dataWord               datRd,
    output logic                  ack
);

    typedef enum logic [1:0] {idle, exec, respond} seqState;

    seqState  state;
    instrWord instrReg;
    logic     illegalFlag;
    logic     zeroFlag;
    dataWord  statusWord;

    logic     req, isInstr, isStatus, isReg;
    regIdx    adrIdx;

    regIdx    rs1, rs2, rd;
    dataWord  imm;
    logic     useImm, legal;
    aluOp     op;

    regIdx    rdIdxA;
    dataWord  rdDataA, rdDataB;
    dataWord  aluOutS;
    logic     zr;
    logic     wrEn;
    regIdx    wrIdx;
    dataWord  wrData;

    assign req      = cyc && stb && (state == idle);  // One access in flight
    assign isInstr  = (adr == adrInstr);
    assign isStatus = (adr == adrStatus);
    assign isReg    = (adr >= adrRegBase);
    assign adrIdx   = regIdx'(adr - adrRegBase);

    instrDecoder dec0 (.instr(instrReg), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
                       .useImm(useImm), .op(op), .legal(legal));

    Alu alu0 (.op(op), .aluInX(rdDataA), .aluInY(useImm ? imm : rdDataB),
              .aluOutS(aluOutS), .zr(zr));

    regFile rf0 (.clk(clk), .rstN(rstN), .rdIdxA(rdIdxA), .rdIdxB(rs2),
                 .rdDataA(rdDataA), .rdDataB(rdDataB), .wrEn(wrEn), .wrIdx(wrIdx),
                 .wrData(wrData));

    // Port A serves the host except during EXEC
    assign rdIdxA = (state == exec) ? rs1 : adrIdx;

    // Write-back and host writes share the one write port
    assign wrEn   = (state == exec) ? legal : (req && we && isReg);
    assign wrIdx  = (state == exec) ? rd : adrIdx;
    assign wrData = (state == exec) ? aluOutS : datWr;

    always_comb begin
        statusWord              = '0;
        statusWord[statIllegal] = illegalFlag;
        statusWord[statZero]    = zeroFlag;
    end

    assign datRd = isReg ? rdDataA : isStatus ? statusWord : '0;

    always_ff @(posedge clk) begin
        if (req && we && isInstr) begin
            instrReg <= datWr;  // Held through EXEC
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= idle;
            ack         <= 1'b0;
            illegalFlag <= 1'b0;
            zeroFlag    <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                idle: begin
                    if (req) begin
                        if (we && isInstr) begin
                            state <= exec;
                        end else begin
                            ack   <= 1'b1;
                            state <= respond;
                            if (we && isStatus) illegalFlag <= 1'b0;
                        end
                    end
                end
                exec: begin
                    if (legal) zeroFlag <= zr;
                    else illegalFlag <= 1'b1;  // Sticky until a status write
                    ack   <= 1'b1;
                    state <= respond;
                end
                respond: begin
                    if (!stb) state <= idle;  // Wait for the master to drop stb
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* source/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import isaPkg::*, aluPkg::*; (
    input  instrWord instr,
    output regIdx    rs1,
    output regIdx    rs2,
    output regIdx    rd,
    output dataWord  imm,
    output logic     useImm,
    output aluOp     op,
    output logic     legal
);

    opcodeField opcode;
    funct3Field funct3;
    funct7Field funct7;
    logic       altSel;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm    = {{20{instr[31]}}, instr[31:20]};  // Sign-extended I-type immediate
    assign useImm = (opcode == opcodeOpImm);
    assign altSel = (funct7 == funct7Alt);

    // funct3 selects the operation and funct7 picks sub or sra
    always_comb begin
        case (funct3)
            addSub: op = (altSel && !useImm) ? opSub : opAdd;  // No subi in RV32I
            sll:    op = opSll;
            slt:    op = opSlt;
            sltu:   op = opSltu;
            xorF:   op = opXor;
            srlSra: op = altSel ? opSra : opSrl;
            orF:    op = opOr;
            andF:   op = opAnd;
            default: op = opAdd;
        endcase
    end

    always_comb begin
        legal = 1'b0;
        if (opcode == opcodeOp) begin
            // Only add/sub and srl/sra have an alternate form
            legal = (funct7 == '0) || (altSel && (funct3 == addSub || funct3 == srlSra));
        end else if (opcode == opcodeOpImm) begin
            case (funct3)
                sll:     legal = (funct7 == '0);            // Upper bits of slli must be zero
                srlSra:  legal = (funct7 == '0) || altSel;  // srli or srai
                default: legal = 1'b1;                      // Full 12-bit immediate
            endcase
        end
    end

endmodule

/* source/isaPkg.sv */
package isaPkg;

    typedef logic [31:0] instrWord;
    typedef logic [4:0]  regIdx;

    // Instruction field widths
    typedef logic [6:0]  opcodeField;
    typedef logic [2:0]  funct3Field;
    typedef logic [6:0]  funct7Field;

    // Major opcodes of the integer ALU classes
    localparam opcodeField opcodeOp    = 7'b0110011;  // Register-register
    localparam opcodeField opcodeOpImm = 7'b0010011;  // Register-immediate

    // funct3 per operation group
    localparam funct3Field addSub = 3'b000;
    localparam funct3Field sll    = 3'b001;
    localparam funct3Field slt    = 3'b010;
    localparam funct3Field sltu   = 3'b011;
    localparam funct3Field xorF   = 3'b100;
    localparam funct3Field srlSra = 3'b101;
    localparam funct3Field orF    = 3'b110;
    localparam funct3Field andF   = 3'b111;

    localparam funct7Field funct7Alt = 7'b0100000;  // Selects sub and sra

endpackage

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile import isaPkg::*, aluPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regIdx   rdIdxA,
    input  regIdx   rdIdxB,
    output dataWord rdDataA,
    output dataWord rdDataB,
    input  logic    wrEn,
    input  regIdx   wrIdx,
    input  dataWord wrData
);

    dataWord regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin  // x0 writes are dropped
            regs[wrIdx] <= wrData;
        end
    end

    // Combinational reads with x0 forced to zero
    assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
    assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

/* verif/execTopTb.sv */
`timescale 1ns/1ps

module execTopTb import isaPkg::*, aluPkg::*;;

    localparam int numInstr   = 300;
    localparam int maxAccess  = 4 * numInstr + 100;
    localparam int watchdogNs = maxAccess * 4 * 8 + 2000;  // 4 cycles of 8 ns per access

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [wbAdrWidth-1:0] adr;
    dataWord               datWr;
    dataWord               datRd;
    logic                  ack;

    dataWord shadow [32];  // Expected register contents
    dataWord expQ [$];     // Expected read data in request order
    logic    zeroExp;
    logic    illegalExp;

    execTop dut0 (.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
                  .datWr(datWr), .datRd(datRd), .ack(ack));

    bind execTop execTop_checker chk0 (.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb),
                                       .we(we), .adr(adr), .datRd(datRd), .ack(ack));

    always #4 clk = ~clk;

    task automatic checkEq(input dataWord got, input dataWord want, input string what);
        if (got !== want) begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, want);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic dataWord refExec(input instrWord ins, input dataWord a,
                                        input dataWord b, output logic ok);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       isImm;
        dataWord    y;
        dataWord    r;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        isImm = (opc == 7'h13);
        y     = isImm ? {{20{ins[31]}}, ins[31:20]} : b;
        if (opc == 7'h33)
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (isImm)
            ok = (f3 == 3'd1) ? (f7 == 7'h00) :
                 (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        else
            ok = 1'b0;  // Not an ALU opcode
        case (f3)
            3'd0: r = (!isImm && f7 == 7'h20) ? a - y : a + y;
            3'd1: r = a << y[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(y)};
            3'd3: r = {31'b0, a < y};
            3'd4: r = a ^ y;
            3'd5: begin
                if (f7 == 7'h20) begin
                    r = $signed(a) >>> y[4:0];  // Sign bit fills in
                end else begin
                    r = a >> y[4:0];
                end
            end
            3'd6: r = a | y;
            default: r = a & y;
        endcase
        return r;
    endfunction

    function automatic dataWord expectedStatus();
        return {30'b0, zeroExp, illegalExp};  // Bit 1 zero, bit 0 illegal
    endfunction

    function automatic instrWord rType(input logic [6:0] f7, input regIdx rs2, input regIdx rs1,
                                       input logic [2:0] f3, input regIdx rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instrWord iType(input logic [11:0] imm, input regIdx rs1,
                                       input logic [2:0] f3, input regIdx rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic instrWord randInstr();
        logic [31:0] r;
        logic [31:0] s;
        logic [11:0] imm;
        logic        alt;
        r   = $urandom;
        s   = $urandom;
        alt = s[1];
        imm = r[29:18];
        if (s[4:2] == 3'd0) r[17:13] = r[12:8];  // Same source twice now and then
        if (!s[0])
            return rType((alt && (r[2:0] == 3'd0 || r[2:0] == 3'd5)) ? 7'h20 : 7'h00,
                         r[17:13], r[12:8], r[2:0], r[7:3]);
        if (r[2:0] == 3'd1) imm[11:5] = 7'h00;
        if (r[2:0] == 3'd5) imm[11:5] = alt ? 7'h20 : 7'h00;
        return iType(imm, r[12:8], r[2:0], r[7:3]);
    endfunction

    // Counts edges from the request edge to the edge where ack is seen
    task automatic awaitAck(input int latency, input string what);
        int cycles;
        @(posedge clk);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (ack !== 1'b1);
        checkEq(32'(cycles), 32'(latency), {what, " ack latency"});
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wbWrite(input logic [wbAdrWidth-1:0] addr, input dataWord data,
                           input int latency);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= addr;
        datWr <= data;
        awaitAck(latency, "write");
    endtask

    task automatic wbRead(input logic [wbAdrWidth-1:0] addr, input dataWord want);
        expQ.push_back(want);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= addr;
        awaitAck(1, "read");
    endtask

    task automatic hostWrite(input regIdx idx, input dataWord data);
        wbWrite(adrRegBase + 6'(idx), data, 1);
        if (idx != '0) shadow[idx] = data;
    endtask

    task automatic checkAllRegs();
        for (int i = 0; i < 32; i++) begin
            wbRead(adrRegBase + 6'(i), shadow[i]);
        end
    endtask

    task automatic runInstr(input instrWord ins);
        dataWord res;
        logic    ok;
        regIdx   rd;
        rd  = ins[11:7];
        res = refExec(ins, shadow[ins[19:15]], shadow[ins[24:20]], ok);
        if (ok) begin
            if (rd != '0) shadow[rd] = res;
            zeroExp = (res == '0);
        end else begin
            illegalExp = 1'b1;
        end
        wbWrite(adrInstr, ins, 2);
        wbRead(adrStatus, expectedStatus());
        wbRead(adrRegBase + 6'(rd), shadow[rd]);
    endtask

    // Each illegal word must raise the flag on its own
    task automatic runIllegal(input instrWord ins);
        runInstr(ins);
        wbWrite(adrStatus, '0, 1);
        illegalExp = 1'b0;
        wbRead(adrStatus, expectedStatus());
    endtask

    // Read data is compared at the edge where the master sees ack
    always @(posedge clk) begin
        dataWord want;
        if (rstN && ack && !we) begin
            if (expQ.size() == 0) begin
                $display("A read was acknowledged with no expected value queued");
                $display("Simulation finished: FAIL");
                $fatal(1, "unexpected read");
            end else begin
                want = expQ.pop_front();
                checkEq(datRd, want, $sformatf("read of address %0d", adr));
            end
        end
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: the bus did not acknowledge within %0d ns", watchdogNs);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        void'($urandom(32'he2e07da7));
        rstN  <= 1'b0;
        cyc   <= 1'b0;
        stb   <= 1'b0;
        we    <= 1'b0;
        adr   <= '0;
        datWr <= '0;
        zeroExp    = 1'b0;
        illegalExp = 1'b0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        checkAllRegs();  // Everything clear after reset
        wbRead(adrStatus, expectedStatus());

        for (int i = 0; i < 20; i++) begin
            r = $urandom;
            hostWrite(r[4:0], $urandom);
        end
        hostWrite(5'd0, 32'hdead_beef);  // Must be dropped
        checkAllRegs();

        for (int i = 1; i < 32; i++) hostWrite(5'(i), $urandom);

        // Signed against unsigned compares and negative shifts
        hostWrite(5'd1, 32'h8000_0000);
        hostWrite(5'd2, 32'h0000_0001);
        hostWrite(5'd3, 32'hffff_fff0);
        runInstr(rType(7'h00, 5'd2, 5'd1, 3'd2, 5'd4));
        runInstr(rType(7'h00, 5'd2, 5'd1, 3'd3, 5'd5));
        runInstr(iType(12'h404, 5'd1, 3'd5, 5'd6));
        runInstr(rType(7'h20, 5'd2, 5'd3, 3'd5, 5'd7));
        runInstr(iType(12'hfff, 5'd3, 3'd3, 5'd8));
        runInstr(rType(7'h20, 5'd1, 5'd1, 3'd0, 5'd9));  // Equal operands give zero

        for (int n = 0; n < numInstr; n++) begin
            r = $urandom;
            if (r[1:0] == 2'd0) hostWrite(r[6:2], $urandom);
            runInstr(randInstr());
        end

        runIllegal(32'h0000_a083);                          // Load opcode
        runIllegal(rType(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));   // Bad funct7 on add
        runIllegal(iType(12'h401, 5'd1, 3'd1, 5'd4));       // slli with funct7 set
        runIllegal(rType(7'h20, 5'd2, 5'd1, 3'd7, 5'd5));   // and has no alternate form
        checkAllRegs();

        @(posedge clk);
        checkEq(32'(expQ.size()), 32'd0, "reads still waiting for a check");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verif/execTop_checker.sv */
`timescale 1ns/1ps

module execTop_checker import aluPkg::*; (
    input logic                  clk,
    input logic                  rstN,
    input logic                  cyc,
    input logic                  stb,
    input logic                  we,
    input logic [wbAdrWidth-1:0] adr,
    input dataWord               datRd,
    input logic                  ack
);

    // An ack only answers a live request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN) ack |-> (cyc && stb))
        else $error("ack high without cyc and stb");

    ackOneCycle: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
        else $error("ack held for more than one cycle");

    x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
        (ack && !we && adr == adrRegBase) |-> (datRd == '0))
        else $error("read of x0 returned a nonzero value");

endmodule
